// File: verilog/csr_pkg.sv
// Register bus definitions. The bus has no handshake, writes take effect on the strobe edge and reads are combinational.
`default_nettype none

package csr_pkg;

localparam int CSR_DATA_W = 8;
localparam int CSR_ADDR_W = 5;

// one request per cycle, the host holds it for a single clock.
typedef struct packed {
	logic [CSR_ADDR_W-1:0] addr;
	logic [CSR_DATA_W-1:0] wdata;
	logic we;
} csr_req_t;

// address map, kept compatible with the existing host driver.
localparam logic [CSR_ADDR_W-1:0] ADDR_VERSION = 5'h03;
localparam logic [CSR_ADDR_W-1:0] ADDR_WDT_CTRL = 5'h04;
localparam logic [CSR_ADDR_W-1:0] ADDR_WDT_TIMEOUT = 5'h05;
localparam logic [CSR_ADDR_W-1:0] ADDR_WDT_KICK = 5'h06;
localparam logic [CSR_ADDR_W-1:0] ADDR_WDT_COUNT = 5'h07;
localparam logic [CSR_ADDR_W-1:0] ADDR_GPO = 5'h1a;
localparam logic [CSR_ADDR_W-1:0] ADDR_GPI = 5'h1b;
localparam logic [CSR_ADDR_W-1:0] ADDR_IRQ_EN = 5'h1c;
localparam logic [CSR_ADDR_W-1:0] ADDR_IRQ_PEND = 5'h1d;

// a kick only counts when this exact value is written.
localparam logic [CSR_DATA_W-1:0] WDT_KICK_KEY = 8'h6b;

localparam logic [CSR_DATA_W-1:0] CORE_VERSION = 8'h08; // reported at ADDR_VERSION.

endpackage

`default_nettype wire

// File: verilog/board_pkg.sv
// Board pin and event types. TICK_DIV is shortened for simulation, and the real board ticks far slower.
`default_nettype none

package board_pkg;

// raw status pins, all active low. Only the first seven are readable.
typedef struct packed {
	logic power_btn_n;
	logic force_recov_n;
	logic sleep_n;
	logic batlow_n;
	logic lid_n;
	logic charging_n;
	logic charger_prsnt_n;
	logic smb_alert_n;
	logic rtc_int_n;
} gpi_t;

// output controls, plain active-high levels.
typedef struct packed {
	logic lcd_vdd_en;
	logic lcd_bklt_en;
	logic emmc_rst;
	logic ptn3460_rst;
	logic ptn3460_pd;
	logic sdio_pwr_en;
} gpo_t;

// one-cycle event pulses. This order is also the bit order of the interrupt registers.
typedef struct packed {
	logic rtc;
	logic smb_alert;
	logic power_btn;
	logic sleep;
	logic wdt;
} irq_src_t;

localparam int IRQ_W = $bits(irq_src_t);
localparam int GPO_W = $bits(gpo_t);

localparam int TICK_DIV = 16; // clocks per watchdog tick.
localparam int TICK_CNT_W = $clog2(TICK_DIV);

localparam logic [7:0] WDT_DEFAULT_TIMEOUT = 8'd8; // in ticks.

localparam gpo_t GPO_RESET = '{sdio_pwr_en: 1'b1, default: 1'b0};

endpackage

`default_nettype wire

// File: verilog/tick_gen.sv
// Clock-enable prescaler. TICK_DIV must be a power of two of at least 2 so the counter width fits exactly.
`default_nettype none

module tick_gen (
	input logic clk,
	input logic rst,
	output logic ce_tick
);

import board_pkg::*;

logic [TICK_CNT_W-1:0] cnt;
logic wrap;

assign wrap = (cnt == TICK_CNT_W'(TICK_DIV - 1));

always_ff @(posedge clk) begin
	if (rst) begin
		cnt <= '0;
		ce_tick <= 1'b0;
	end else begin
		ce_tick <= wrap; // first tick lands TICK_DIV clocks after reset.
		cnt <= wrap ? '0 : cnt + 1'b1;
	end
end

// the watchdog counts one step per tick, so a held tick would run it too fast.
a_tick_single: assert property (@(posedge clk) disable iff (rst) ce_tick |=> !ce_tick)
	else $error("ce_tick stayed high for two cycles.");

endmodule

`default_nettype wire

// File: verilog/input_sync.sv
// Status pin synchronizer with no reset, so events are unknown for the first three clocks and must be masked by reset downstream.
`default_nettype none

module input_sync (
	input logic clk,
	input board_pkg::gpi_t pins,
	output board_pkg::gpi_t pins_sync,
	output board_pkg::irq_src_t events
);

import board_pkg::*;

gpi_t sync1;
gpi_t prev;

// two stages against metastability, then one more to compare against.
always_ff @(posedge clk) begin
	sync1 <= pins;
	pins_sync <= sync1;
	prev <= pins_sync;
end

always_comb begin
	events = '0; // wdt is merged in at the top level.
	events.rtc = prev.rtc_int_n & ~pins_sync.rtc_int_n;
	events.smb_alert = prev.smb_alert_n & ~pins_sync.smb_alert_n;
	events.sleep = prev.sleep_n & ~pins_sync.sleep_n;
	// press and release both count.
	events.power_btn = prev.power_btn_n ^ pins_sync.power_btn_n;
end

endmodule

`default_nettype wire

// File: verilog/board_regs.sv
// Version, status readback and output registers. Pins read back raw and active low, and the version is fixed at build time.
`default_nettype none

module board_regs (
	input logic clk,
	input logic rst,
	input csr_pkg::csr_req_t csr_req,
	output logic [csr_pkg::CSR_DATA_W-1:0] rdata,
	input board_pkg::gpi_t pins_sync,
	output board_pkg::gpo_t gpo
);

import csr_pkg::*;
import board_pkg::*;

logic gpo_we;
logic [CSR_DATA_W-1:0] gpi_word;

assign gpo_we = csr_req.we && (csr_req.addr == ADDR_GPO);

// bit 0 is the power button, as in the older register layout.
assign gpi_word = {
	1'b0,
	pins_sync.charger_prsnt_n,
	pins_sync.charging_n,
	pins_sync.lid_n,
	pins_sync.batlow_n,
	pins_sync.sleep_n,
	pins_sync.force_recov_n,
	pins_sync.power_btn_n
};

always_ff @(posedge clk) begin
	if (rst)
		gpo <= GPO_RESET;
	else if (gpo_we)
		gpo <= gpo_t'(csr_req.wdata[GPO_W-1:0]);
end

always_comb begin
	case (csr_req.addr)
	ADDR_VERSION: rdata = CORE_VERSION;
	ADDR_GPI: rdata = gpi_word;
	ADDR_GPO: rdata = CSR_DATA_W'(gpo); // upper bits read as zero.
	default: rdata = '0;
	endcase
end

endmodule

`default_nettype wire

// File: verilog/irq_ctrl.sv
// Interrupt controller with level output. A source pulse in the same cycle as its clear keeps the bit pending.
`default_nettype none

module irq_ctrl (
	input logic clk,
	input logic rst,
	input csr_pkg::csr_req_t csr_req,
	output logic [csr_pkg::CSR_DATA_W-1:0] rdata,
	input board_pkg::irq_src_t events,
	output logic irq
);

import csr_pkg::*;
import board_pkg::*;

logic [IRQ_W-1:0] en;
logic [IRQ_W-1:0] pend;
logic [IRQ_W-1:0] clr;
logic en_we;
logic pend_we;

assign en_we = csr_req.we && (csr_req.addr == ADDR_IRQ_EN);
assign pend_we = csr_req.we && (csr_req.addr == ADDR_IRQ_PEND);

// write one to clear.
assign clr = pend_we ? csr_req.wdata[IRQ_W-1:0] : '0;

always_ff @(posedge clk) begin
	if (rst) begin
		en <= '0;
		pend <= '0;
		irq <= 1'b0;
	end else begin
		if (en_we)
			en <= csr_req.wdata[IRQ_W-1:0];
		pend <= (pend & ~clr) | events; // new events win over the clear.
		irq <= |(pend & en);
	end
end

always_comb begin
	case (csr_req.addr)
	ADDR_IRQ_EN: rdata = CSR_DATA_W'(en);
	ADDR_IRQ_PEND: rdata = CSR_DATA_W'(pend);
	default: rdata = '0;
	endcase
end

// the host must never see an interrupt it cannot find in the pending register.
a_irq_cause: assert property (@(posedge clk) disable iff (rst) irq |-> $past(|(pend & en)))
	else $error("irq raised without an enabled pending bit.");

endmodule

`default_nettype wire

// File: verilog/watchdog.sv
// Tick-based watchdog. A timeout of zero never expires, and kicks reload the counter even while disabled.
`default_nettype none

module watchdog (
	input logic clk,
	input logic rst,
	input logic ce_tick,
	input csr_pkg::csr_req_t csr_req,
	output logic [csr_pkg::CSR_DATA_W-1:0] rdata,
	output logic wdt_timeout,
	output logic wdt_expired
);

import csr_pkg::*;
import board_pkg::*;

logic enable;
logic [CSR_DATA_W-1:0] timeout;
logic [CSR_DATA_W-1:0] count;
logic ctrl_we;
logic timeout_we;
logic kick;
logic load;
logic run;

assign ctrl_we = csr_req.we && (csr_req.addr == ADDR_WDT_CTRL);
assign timeout_we = csr_req.we && (csr_req.addr == ADDR_WDT_TIMEOUT);
assign kick = csr_req.we && (csr_req.addr == ADDR_WDT_KICK) && (csr_req.wdata == WDT_KICK_KEY);

// enabling and kicking both start a fresh period.
assign load = (ctrl_we && csr_req.wdata[0]) || kick;

// a disable write in the same cycle as a tick must not let the tick expire.
assign run = enable && !ctrl_we && ce_tick && (count != '0);

always_ff @(posedge clk) begin
	if (rst) begin
		enable <= 1'b0;
		timeout <= WDT_DEFAULT_TIMEOUT;
		count <= WDT_DEFAULT_TIMEOUT;
		wdt_timeout <= 1'b0;
		wdt_expired <= 1'b0;
	end else begin
		wdt_expired <= 1'b0;
		if (ctrl_we) begin
			enable <= csr_req.wdata[0];
			if (!csr_req.wdata[0])
				wdt_timeout <= 1'b0;
		end
		if (timeout_we)
			timeout <= csr_req.wdata;
		if (load) begin
			count <= timeout;
		end else if (run) begin
			count <= count - 1'b1;
			if (count == CSR_DATA_W'(1)) begin
				wdt_timeout <= 1'b1; // held until disabled.
				wdt_expired <= 1'b1;
			end
		end
	end
end

always_comb begin
	case (csr_req.addr)
	ADDR_WDT_CTRL: rdata = CSR_DATA_W'({wdt_timeout, enable}); // bit 1 is read-only status.
	ADDR_WDT_TIMEOUT: rdata = timeout;
	ADDR_WDT_COUNT: rdata = count;
	default: rdata = '0;
	endcase
end

// expiry is only ever caused by a tick, never by a register write.
a_expire_on_tick: assert property (
	@(posedge clk) disable iff (rst) $rose(wdt_expired) |-> $past(ce_tick)
) else $error("wdt_expired rose without a preceding tick.");

endmodule

`default_nettype wire

// File: verilog/mgmt_top.sv
// Board management core. Every unit decodes the full address itself, so unused addresses read as zero.
`default_nettype none

module mgmt_top (
	input logic clk,
	input logic rst,
	input csr_pkg::csr_req_t csr_req,
	output logic [csr_pkg::CSR_DATA_W-1:0] csr_rdata,
	input board_pkg::gpi_t pins,
	output board_pkg::gpo_t gpo,
	output logic irq,
	output logic wdt_timeout
);

import csr_pkg::*;
import board_pkg::*;

logic ce_tick;
gpi_t pins_sync;
irq_src_t sync_events;
irq_src_t irq_events;
logic wdt_expired;
logic [CSR_DATA_W-1:0] regs_rdata;
logic [CSR_DATA_W-1:0] irq_rdata;
logic [CSR_DATA_W-1:0] wdt_rdata;

tick_gen tick_gen (
	.clk(clk),
	.rst(rst),
	.ce_tick(ce_tick)
);

input_sync input_sync (
	.clk(clk),
	.pins(pins),
	.pins_sync(pins_sync),
	.events(sync_events)
);

board_regs board_regs (
	.clk(clk),
	.rst(rst),
	.csr_req(csr_req),
	.rdata(regs_rdata),
	.pins_sync(pins_sync),
	.gpo(gpo)
);

// the watchdog is the only source that does not come from a pin.
always_comb begin
	irq_events = sync_events;
	irq_events.wdt = wdt_expired;
end

irq_ctrl irq_ctrl (
	.clk(clk),
	.rst(rst),
	.csr_req(csr_req),
	.rdata(irq_rdata),
	.events(irq_events),
	.irq(irq)
);

watchdog watchdog (
	.clk(clk),
	.rst(rst),
	.ce_tick(ce_tick),
	.csr_req(csr_req),
	.rdata(wdt_rdata),
	.wdt_timeout(wdt_timeout),
	.wdt_expired(wdt_expired)
);

assign csr_rdata = regs_rdata | irq_rdata | wdt_rdata;

endmodule

`default_nettype wire

// File: sim/mgmt_tb.sv
// Self-checking testbench. Expects TICK_DIV small enough for the watchdog checks to run quickly.
`default_nettype none

module mgmt_tb;

import csr_pkg::*;
import board_pkg::*;

// the tests take roughly 1500 cycles at most, so twice that ends a hung run.
localparam int TEST_CYCLES = 1500;
localparam int MAX_CYCLES = 2 * TEST_CYCLES;

// what the stimulus wants checked at the next rising edge.
typedef struct packed {
	logic rd_on;
	logic [CSR_DATA_W-1:0] rd;
	logic lvl_on;
	logic irq;
	logic wdt;
} expect_t;

logic clk;
logic rst;
csr_req_t csr_req;
logic [CSR_DATA_W-1:0] csr_rdata;
gpi_t pins;
gpo_t gpo;
logic irq;
logic wdt_timeout;

expect_t chk;
logic [GPO_W-1:0] gpo_model;
logic [7:0] lfsr_state;
logic wdt_watch;
int wdt_cycles;
int cycles = 0;
int errors = 0;
int errors_at_start = 0;
int tests_done = 0;

mgmt_top UUT (
	.clk(clk),
	.rst(rst),
	.csr_req(csr_req),
	.csr_rdata(csr_rdata),
	.pins(pins),
	.gpo(gpo),
	.irq(irq),
	.wdt_timeout(wdt_timeout)
);

always #5 clk = ~clk;

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycles == MAX_CYCLES) begin
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end
end

// a write lands at the edge where we is high. Only the SD power enable is set after reset.
always @(posedge clk) begin
	if (rst)
		gpo_model <= 6'b000001;
	else if (csr_req.we && csr_req.addr == ADDR_GPO)
		gpo_model <= csr_req.wdata[GPO_W-1:0];
end

always @(posedge clk) begin
	if (wdt_watch)
		wdt_cycles <= wdt_cycles + 1;
	else
		wdt_cycles <= 0;
end

function automatic logic [7:0] lfsr_step(input logic [7:0] s);
	return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]}; // x^8 + x^6 + x^5 + x^4 + 1.
endfunction

function automatic logic [7:0] take_bits(input int n);
	logic [7:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		r = {r[6:0], lfsr_state[0]};
	end
	return r;
endfunction

// the readable fields fill the status register from bit 0 in declaration order.
function automatic logic [7:0] gpi_word_of(input gpi_t p);
	logic [7:0] w;
	w = '0;
	for (int i = 0; i < 7; i++)
		w[i] = p[$bits(gpi_t) - 1 - i];
	return w;
endfunction

task automatic flag_error(input string what, input logic [7:0] got, input logic [7:0] want);
	errors++;
	$display("** Error at time %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, want);
endtask

task automatic write_reg(input logic [CSR_ADDR_W-1:0] addr, input logic [7:0] data);
	csr_req.addr = addr;
	csr_req.wdata = data;
	csr_req.we = 1'b1;
	@(negedge clk);
	csr_req = '0;
endtask

task automatic read_expect(input logic [CSR_ADDR_W-1:0] addr, input logic [7:0] want);
	csr_req.addr = addr;
	csr_req.we = 1'b0;
	chk.rd_on = 1'b1;
	chk.rd = want;
	@(negedge clk);
	chk.rd_on = 1'b0;
	csr_req = '0;
endtask

task automatic expect_levels(input logic want_irq, input logic want_wdt);
	chk.lvl_on = 1'b1;
	chk.irq = want_irq;
	chk.wdt = want_wdt;
	@(negedge clk);
	chk.lvl_on = 1'b0;
endtask

task automatic finish_test(input string name);
	tests_done++;
	$display("test %0d (%s) finished with %0d errors", tests_done, name, errors - errors_at_start);
	errors_at_start = errors;
endtask

a_read: assert property (@(posedge clk) disable iff (rst) chk.rd_on |-> csr_rdata == chk.rd)
	else flag_error("read data", $sampled(csr_rdata), chk.rd);

a_levels: assert property (@(posedge clk) disable iff (rst)
	chk.lvl_on |-> (irq == chk.irq && wdt_timeout == chk.wdt))
	else flag_error("{irq, wdt_timeout}", {6'b0, $sampled(irq), $sampled(wdt_timeout)},
		{6'b0, chk.irq, chk.wdt});

a_gpo: assert property (@(posedge clk) disable iff (rst) gpo == gpo_model)
	else flag_error("gpo", {2'b00, $sampled(gpo)}, {2'b00, gpo_model});

// with timeout 4 the expiry is 3 to 4 ticks after the enable write.
a_wdt_window: assert property (@(posedge clk) disable iff (rst)
	(wdt_watch && $rose(wdt_timeout)) |->
		(wdt_cycles >= 3 * TICK_DIV && wdt_cycles <= 5 * TICK_DIV))
	else begin
		errors++;
		$display("** Error at time %0t: watchdog expired after %0d cycles, expected %0d to %0d",
			$time, wdt_cycles, 3 * TICK_DIV, 5 * TICK_DIV);
	end

initial begin
	logic [7:0] r;
	int waited;
	clk = 1'b0;
	rst = 1'b1;
	csr_req = '0;
	pins = '1; // all status pins inactive.
	chk = '0;
	wdt_watch = 1'b0;
	lfsr_state = 8'd44;
	repeat (5) @(negedge clk);
	rst = 1'b0;

	read_expect(ADDR_VERSION, CORE_VERSION);
	read_expect(ADDR_GPO, 8'h01);
	read_expect(ADDR_WDT_TIMEOUT, 8'd8);
	read_expect(ADDR_IRQ_EN, 8'h00);
	expect_levels(1'b0, 1'b0);
	finish_test("after reset");

	repeat (12) begin
		r = take_bits(6);
		write_reg(ADDR_GPO, {2'b00, r[5:0]});
		read_expect(ADDR_GPO, {2'b00, r[5:0]});
	end
	finish_test("output control");

	// rtc and smb alert only make edges, so they stay high here.
	repeat (8) begin
		r = take_bits(7);
		pins = {r[6:0], 2'b11};
		repeat (3) @(negedge clk);
		read_expect(ADDR_GPI, gpi_word_of(pins));
	end
	finish_test("status readback");

	pins = '1;
	repeat (6) @(negedge clk);
	write_reg(ADDR_IRQ_PEND, 8'h1f);
	write_reg(ADDR_IRQ_EN, 8'h10); // rtc only.
	read_expect(ADDR_IRQ_PEND, 8'h00);
	pins.rtc_int_n = 1'b0;
	repeat (6) @(negedge clk);
	expect_levels(1'b1, 1'b0);
	read_expect(ADDR_IRQ_PEND, 8'h10);
	pins.rtc_int_n = 1'b1;
	write_reg(ADDR_IRQ_PEND, 8'h10);
	@(negedge clk);
	expect_levels(1'b0, 1'b0);
	pins.smb_alert_n = 1'b0;
	repeat (6) @(negedge clk);
	expect_levels(1'b0, 1'b0);
	read_expect(ADDR_IRQ_PEND, 8'h08);
	pins.smb_alert_n = 1'b1;
	write_reg(ADDR_IRQ_PEND, 8'h08);
	pins.power_btn_n = 1'b0;
	repeat (6) @(negedge clk);
	read_expect(ADDR_IRQ_PEND, 8'h04);
	write_reg(ADDR_IRQ_PEND, 8'h04);
	pins.power_btn_n = 1'b1;
	repeat (6) @(negedge clk);
	read_expect(ADDR_IRQ_PEND, 8'h04);
	write_reg(ADDR_IRQ_PEND, 8'h04);
	read_expect(ADDR_IRQ_PEND, 8'h00);
	finish_test("interrupts");

	write_reg(ADDR_IRQ_EN, 8'h00);
	write_reg(ADDR_WDT_TIMEOUT, 8'd4);
	read_expect(ADDR_WDT_TIMEOUT, 8'd4);
	write_reg(ADDR_WDT_CTRL, 8'h01);
	wdt_watch = 1'b1;
	waited = 0;
	while (!wdt_timeout && waited < 6 * TICK_DIV) begin
		@(negedge clk);
		waited++;
	end
	if (!wdt_timeout) begin
		errors++;
		$display("watchdog never expired within %0d cycles of being enabled", 6 * TICK_DIV);
	end
	@(negedge clk); // let the window check see the rising edge.
	wdt_watch = 1'b0;
	@(negedge clk);
	read_expect(ADDR_IRQ_PEND, 8'h01);
	expect_levels(1'b0, 1'b1);
	write_reg(ADDR_WDT_CTRL, 8'h00);
	expect_levels(1'b0, 1'b0);
	write_reg(ADDR_WDT_CTRL, 8'h01);
	chk.lvl_on = 1'b1;
	chk.irq = 1'b0;
	chk.wdt = 1'b0;
	repeat (10) begin
		write_reg(ADDR_WDT_KICK, WDT_KICK_KEY);
		repeat (2 * TICK_DIV - 1) @(negedge clk);
	end
	chk.lvl_on = 1'b0;
	write_reg(ADDR_WDT_CTRL, 8'h00);
	finish_test("watchdog");

	@(negedge clk);
	$display("tests run: %0d, errors: %0d", tests_done, errors);
	if (errors == 0)
		$display("NO ERRORS");
	else
		$display("ERRORS FOUND");
	$finish;
end

endmodule

`default_nettype wire

// File: build.f
verilog/csr_pkg.sv
verilog/board_pkg.sv
verilog/tick_gen.sv
verilog/input_sync.sv
verilog/board_regs.sv
verilog/irq_ctrl.sv
verilog/watchdog.sv
verilog/mgmt_top.sv
sim/mgmt_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module mgmt_tb -Mdir obj_dir -f build.f
	./obj_dir/Vmgmt_tb | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
